/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

   // major opcode field, bits [6:0] of the instruction
   typedef enum logic [6:0] {
      opc_op     = 7'b0110011,
      opc_op_imm = 7'b0010011,
      opc_lui    = 7'b0110111,
      opc_branch = 7'b1100011,
      opc_jal    = 7'b1101111
   } rv_opcode_e;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt,
      alu_sll,
      alu_srl,
      // second operand straight through, used by lui
      alu_pass_b
   } rv_alu_op_e;

   typedef enum logic [2:0] {
      br_none,
      br_beq,
      br_bne,
      br_blt,
      br_jal
   } rv_br_op_e;

   // decoded control, one word per instruction
   typedef struct packed {
      rv_alu_op_e alu_op;
      rv_br_op_e  br_op;
      logic       use_imm;
      logic       reg_write;
      logic       valid;
   } rv_ctrl_t;

endpackage

`default_nettype wire

/* logic/rv_exec_if.sv */
`default_nettype none
`timescale 1ns/100ps

// execute stage operands, shared by the alu and the branch unit
interface rv_exec_if;
   import rv_pkg::*;

   logic [31:0] pc;
   logic [31:0] rs1_val;
   logic [31:0] rs2_val;
   logic [31:0] imm;
   rv_ctrl_t    ctrl;

   modport core (
      output pc, rs1_val, rs2_val, imm, ctrl
   );

   modport unit (
      input pc, rs1_val, rs2_val, imm, ctrl
   );

endinterface

`default_nettype wire

/* logic/rv_decoder.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_decoder #(
   parameter int num_regs = 32
) (
   input  logic [31:0]     instr_i,
   output logic [4:0]      rs1_o,
   output logic [4:0]      rs2_o,
   output logic [4:0]      rd_o,
   output logic [31:0]     imm_o,
   output rv_pkg::rv_ctrl_t ctrl_o
);
   import rv_pkg::*;

   logic [6:0]  funct7;
   logic [2:0]  funct3;
   logic [31:0] imm_i;
   logic [31:0] imm_b;
   logic [31:0] imm_u;
   logic [31:0] imm_j;
   logic        known;
   logic        uses_rs1;
   logic        uses_rs2;
   logic        bad_index;

   assign rs1_o  = instr_i[19:15];
   assign rs2_o  = instr_i[24:20];
   assign rd_o   = instr_i[11:7];
   assign funct7 = instr_i[31:25];
   assign funct3 = instr_i[14:12];

   // sign extended immediates of each format
   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
   assign imm_u = {instr_i[31:12], 12'b0};
   assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

   always_comb begin
      ctrl_o.alu_op    = alu_add;
      ctrl_o.br_op     = br_none;
      ctrl_o.use_imm   = 1'b0;
      ctrl_o.reg_write = 1'b0;
      imm_o            = imm_i;
      known            = 1'b1;
      uses_rs1         = 1'b1;
      uses_rs2         = 1'b0;
      case (instr_i[6:0])
         opc_op: begin
            ctrl_o.reg_write = 1'b1;
            uses_rs2         = 1'b1;
            case ({funct7, funct3})
               {7'h00, 3'b000}: ctrl_o.alu_op = alu_add;
               {7'h20, 3'b000}: ctrl_o.alu_op = alu_sub;
               {7'h00, 3'b111}: ctrl_o.alu_op = alu_and;
               {7'h00, 3'b110}: ctrl_o.alu_op = alu_or;
               {7'h00, 3'b100}: ctrl_o.alu_op = alu_xor;
               {7'h00, 3'b010}: ctrl_o.alu_op = alu_slt;
               {7'h00, 3'b001}: ctrl_o.alu_op = alu_sll;
               {7'h00, 3'b101}: ctrl_o.alu_op = alu_srl;
               default:         known = 1'b0;
            endcase
         end
         opc_op_imm: begin
            ctrl_o.reg_write = 1'b1;
            ctrl_o.use_imm   = 1'b1;
            case (funct3)
               3'b000:  ctrl_o.alu_op = alu_add;
               3'b111:  ctrl_o.alu_op = alu_and;
               3'b110:  ctrl_o.alu_op = alu_or;
               3'b100:  ctrl_o.alu_op = alu_xor;
               default: known = 1'b0;
            endcase
         end
         opc_lui: begin
            ctrl_o.alu_op    = alu_pass_b;
            ctrl_o.use_imm   = 1'b1;
            ctrl_o.reg_write = 1'b1;
            imm_o            = imm_u;
            uses_rs1         = 1'b0;
         end
         opc_branch: begin
            imm_o    = imm_b;
            uses_rs2 = 1'b1;
            case (funct3)
               3'b000:  ctrl_o.br_op = br_beq;
               3'b001:  ctrl_o.br_op = br_bne;
               3'b100:  ctrl_o.br_op = br_blt;
               default: known = 1'b0;
            endcase
         end
         opc_jal: begin
            ctrl_o.br_op     = br_jal;
            ctrl_o.reg_write = 1'b1;
            imm_o            = imm_j;
            uses_rs1         = 1'b0;
         end
         default: begin
            known            = 1'b0;
            uses_rs1         = 1'b0;
         end
      endcase
      // indices beyond the register count, e.g. x16 and up on rv32e
      bad_index = (ctrl_o.reg_write && rd_o >= num_regs) ||
                  (uses_rs1 && rs1_o >= num_regs) ||
                  (uses_rs2 && rs2_o >= num_regs);
      ctrl_o.valid = known && !bad_index;
   end

endmodule

`default_nettype wire

/* logic/rv_reg_file.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_reg_file #(
   parameter int num_regs = 32
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [4:0]  rs1_i,
   input  logic [4:0]  rs2_i,
   input  logic [4:0]  rd_i,
   input  logic        we_i,
   input  logic [31:0] wdata_i,
   output logic [31:0] rs1_data_o,
   output logic [31:0] rs2_data_o
);

   logic [31:0] regs [num_regs];

   // x0 and out of range indices read as zero, a same cycle write passes through
   function automatic logic [31:0] read_port(input logic [4:0] idx);
      if (idx == 5'd0 || idx >= num_regs)
         return 32'd0;
      if (we_i && idx == rd_i)
         return wdata_i;
      return regs[idx];
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_regs; i++)
            regs[i] <= 32'd0;
      end else if (we_i && rd_i != 5'd0 && rd_i < num_regs) begin
         regs[rd_i] <= wdata_i;
      end
   end

   always_comb begin
      rs1_data_o = read_port(rs1_i);
      rs2_data_o = read_port(rs2_i);
   end

endmodule

`default_nettype wire

/* logic/rv_alu.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_alu (
   rv_exec_if.unit     ex,
   output logic [31:0] result_o
);
   import rv_pkg::*;

   logic [31:0] op_a;
   logic [31:0] op_b;
   logic [4:0]  shamt;

   assign op_a = ex.rs1_val;
   // immediate group and lui take the immediate
   assign op_b  = ex.ctrl.use_imm ? ex.imm : ex.rs2_val;
   assign shamt = op_b[4:0];

   always_comb begin
      case (ex.ctrl.alu_op)
         alu_add:    result_o = op_a + op_b;
         alu_sub:    result_o = op_a - op_b;
         alu_and:    result_o = op_a & op_b;
         alu_or:     result_o = op_a | op_b;
         alu_xor:    result_o = op_a ^ op_b;
         alu_slt:    result_o = {31'd0, $signed(op_a) < $signed(op_b)};
         alu_sll:    result_o = op_a << shamt;
         alu_srl:    result_o = op_a >> shamt;
         alu_pass_b: result_o = op_b;
         default:    result_o = 32'd0;
      endcase
   end

endmodule

`default_nettype wire

/* logic/rv_branch_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_branch_unit (
   rv_exec_if.unit     ex,
   output logic        taken_o,
   output logic [31:0] target_o,
   output logic [31:0] link_o
);
   import rv_pkg::*;

   logic equal;
   logic less;
   logic cond;

   assign equal = ex.rs1_val == ex.rs2_val;
   assign less  = $signed(ex.rs1_val) < $signed(ex.rs2_val);

   always_comb begin
      case (ex.ctrl.br_op)
         br_beq:  cond = equal;
         br_bne:  cond = !equal;
         br_blt:  cond = less;
         br_jal:  cond = 1'b1;
         default: cond = 1'b0;
      endcase
   end

   // bubbles never redirect
   assign taken_o = ex.ctrl.valid && cond;

   // both branch and jal are pc relative
   assign target_o = ex.pc + ex.imm;
   assign link_o   = ex.pc + 32'd4;

endmodule

`default_nettype wire

/* logic/rv_core.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_core #(
   parameter int          num_regs = 32,
   parameter logic [31:0] reset_pc = 32'h0000_0000
) (
   input  logic        clk,
   input  logic        reset,
   output logic [31:0] imem_addr_o,
   input  logic [31:0] imem_data_i,
   output logic        retire_valid_o,
   output logic [31:0] retire_pc_o,
   output logic [4:0]  retire_rd_o,
   output logic [31:0] retire_data_o
);
   import rv_pkg::*;

   logic [31:0] pc_q;

   // if/id
   logic        if_id_valid;
   logic [31:0] if_id_pc;
   logic [31:0] if_id_instr;

   // decode outputs
   logic [4:0]  dec_rs1;
   logic [4:0]  dec_rs2;
   logic [4:0]  dec_rd;
   logic [31:0] dec_imm;
   rv_ctrl_t    dec_ctrl;
   rv_ctrl_t    id_ctrl;
   logic [31:0] rf_rs1_data;
   logic [31:0] rf_rs2_data;

   // id/ex
   rv_ctrl_t    id_ex_ctrl;
   logic [31:0] id_ex_pc;
   logic [4:0]  id_ex_rs1;
   logic [4:0]  id_ex_rs2;
   logic [4:0]  id_ex_rd;
   logic [31:0] id_ex_rs1_val;
   logic [31:0] id_ex_rs2_val;
   logic [31:0] id_ex_imm;

   // execute results
   logic [31:0] alu_result;
   logic        br_taken;
   logic [31:0] br_target;
   logic [31:0] br_link;
   logic [31:0] ex_result;

   // ex/wb, rd is zero for instructions that write nothing
   logic        ex_wb_valid;
   logic [31:0] ex_wb_pc;
   logic [4:0]  ex_wb_rd;
   logic [31:0] ex_wb_result;

   rv_exec_if ex_bus ();

   function automatic logic [31:0] forward(input logic [4:0]  src,
                                           input logic [31:0] reg_val);
      if (ex_wb_valid && ex_wb_rd != 5'd0 && ex_wb_rd == src)
         return ex_wb_result;
      return reg_val;
   endfunction

   assign imem_addr_o = pc_q;

   rv_decoder #(
      .num_regs(num_regs)
   ) u_decoder (
      .instr_i(if_id_instr),
      .rs1_o  (dec_rs1),
      .rs2_o  (dec_rs2),
      .rd_o   (dec_rd),
      .imm_o  (dec_imm),
      .ctrl_o (dec_ctrl)
   );

   rv_reg_file #(
      .num_regs(num_regs)
   ) u_reg_file (
      .clk       (clk),
      .reset     (reset),
      .rs1_i     (dec_rs1),
      .rs2_i     (dec_rs2),
      .rd_i      (ex_wb_rd),
      .we_i      (ex_wb_valid),
      .wdata_i   (ex_wb_result),
      .rs1_data_o(rf_rs1_data),
      .rs2_data_o(rf_rs2_data)
   );

   always_comb begin
      id_ctrl       = dec_ctrl;
      id_ctrl.valid = dec_ctrl.valid && if_id_valid;
   end

   // operands into execute, distance one comes from the ex/wb register
   assign ex_bus.pc   = id_ex_pc;
   assign ex_bus.imm  = id_ex_imm;
   assign ex_bus.ctrl = id_ex_ctrl;

   always_comb begin
      ex_bus.rs1_val = forward(id_ex_rs1, id_ex_rs1_val);
      ex_bus.rs2_val = forward(id_ex_rs2, id_ex_rs2_val);
   end

   rv_alu u_alu (
      .ex      (ex_bus),
      .result_o(alu_result)
   );

   rv_branch_unit u_branch_unit (
      .ex      (ex_bus),
      .taken_o (br_taken),
      .target_o(br_target),
      .link_o  (br_link)
   );

   assign ex_result = (id_ex_ctrl.br_op == br_jal) ? br_link : alu_result;

   // control state, a taken branch squashes if/id and id/ex
   always_ff @(posedge clk) begin
      if (reset) begin
         pc_q        <= reset_pc;
         if_id_valid <= 1'b0;
         id_ex_ctrl  <= '0;
         ex_wb_valid <= 1'b0;
      end else begin
         pc_q        <= br_taken ? br_target : pc_q + 32'd4;
         if_id_valid <= !br_taken;
         id_ex_ctrl  <= br_taken ? '0 : id_ctrl;
         ex_wb_valid <= id_ex_ctrl.valid;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if_id_pc      <= pc_q;
      if_id_instr   <= imem_data_i;
      id_ex_pc      <= if_id_pc;
      id_ex_rs1     <= dec_rs1;
      id_ex_rs2     <= dec_rs2;
      id_ex_rd      <= dec_rd;
      id_ex_rs1_val <= rf_rs1_data;
      id_ex_rs2_val <= rf_rs2_data;
      id_ex_imm     <= dec_imm;
      ex_wb_pc      <= id_ex_pc;
      ex_wb_rd      <= id_ex_ctrl.reg_write ? id_ex_rd : 5'd0;
      ex_wb_result  <= ex_result;
   end

   assign retire_valid_o = ex_wb_valid;
   assign retire_pc_o    = ex_wb_pc;
   assign retire_rd_o    = ex_wb_rd;
   assign retire_data_o  = ex_wb_result;

endmodule

`default_nettype wire

/* tests/rv_core_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module rv_core_tb;

   localparam logic [31:0] reset_pc = 32'h0000_0040;
   localparam int mem_words      = 64;
   localparam int max_prog_words = 24;
   localparam int reset_cycles   = 4;
   localparam int num_tests      = 6;
   // program, reset and pipeline drain per test plus slack
   localparam int timeout_cycles = num_tests * (max_prog_words + reset_cycles + 16) + 20;

   localparam logic [2:0] f3_add = 3'b000;
   localparam logic [2:0] f3_sll = 3'b001;
   localparam logic [2:0] f3_slt = 3'b010;
   localparam logic [2:0] f3_xor = 3'b100;
   localparam logic [2:0] f3_srl = 3'b101;
   localparam logic [2:0] f3_or  = 3'b110;
   localparam logic [2:0] f3_and = 3'b111;
   localparam logic [2:0] f3_beq = 3'b000;
   localparam logic [2:0] f3_bne = 3'b001;
   localparam logic [2:0] f3_blt = 3'b100;
   localparam logic [6:0] f7_sub = 7'h20;

   logic        clk;
   logic        reset;
   logic [31:0] imem_addr;
   logic [31:0] imem_data;
   logic        retire_valid;
   logic [31:0] retire_pc;
   logic [4:0]  retire_rd;
   logic [31:0] retire_data;

   logic [31:0] imem [mem_words];
   logic [31:0] model_regs [32];
   int          load_ptr;
   logic [31:0] sentinel_pc;
   int          cycle_count;
   int          error_count;
   int          check_count;
   int          test_errors;

   // expected and observed retire events
   logic [31:0] exp_pc [$];
   logic [4:0]  exp_rd [$];
   logic [31:0] exp_data [$];
   logic        exp_has_data [$];
   logic [31:0] got_pc [$];
   logic [4:0]  got_rd [$];
   logic [31:0] got_data [$];

   rv_core #(
      .num_regs(32),
      .reset_pc(reset_pc)
   ) DUT (
      .clk           (clk),
      .reset         (reset),
      .imem_addr_o   (imem_addr),
      .imem_data_i   (imem_data),
      .retire_valid_o(retire_valid),
      .retire_pc_o   (retire_pc),
      .retire_rd_o   (retire_rd),
      .retire_data_o (retire_data)
   );

   // combinational fetch by word index
   assign imem_data = imem[imem_addr[7:2]];

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout after %0d cycles, the sentinel never retired", timeout_cycles);
         $display("Regression failed");
         $finish;
      end
   end

   function automatic logic [31:0] op_rr(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] op_imm(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] upper);
      return {upper, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
   endfunction

   function automatic logic [11:0] random_imm12();
      logic [31:0] r;
      r = $urandom;
      return r[11:0];
   endfunction

   task automatic check_value(input string test, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         test_errors++;
         $display("[FAIL] %s %s: expected %h, actual %h", test, what, expected, actual);
      end
   endtask

   // unknown opcode everywhere with the word index in the upper bits
   task automatic new_program();
      for (int i = 0; i < mem_words; i++)
         imem[i] = {i[24:0], 7'h7f};
      load_ptr    = 0;
      test_errors = 0;
   endtask

   task automatic put_word(input logic [31:0] word);
      if (load_ptr >= max_prog_words) begin
         $display("program does not fit in %0d words", max_prog_words);
         error_count++;
         test_errors++;
      end else begin
         imem[reset_pc[7:2] + load_ptr] = word;
         load_ptr++;
      end
   endtask

   // self loop that ends the run once it retires
   task automatic end_program();
      sentinel_pc = reset_pc + load_ptr * 4;
      put_word(jal_word(5'd0, 21'd0));
   endtask

   task automatic retire_expected(input logic [31:0] pc, input logic [4:0] rd,
                                  input logic [31:0] data, input logic has_data);
      exp_pc.push_back(pc);
      exp_rd.push_back(rd);
      exp_data.push_back(data);
      exp_has_data.push_back(has_data);
      if (has_data && rd != 5'd0)
         model_regs[rd] = data;
   endtask

   // instruction level model of the program in memory
   task automatic build_expected();
      logic [31:0] pc;
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] val;
      logic [31:0] imm_i;
      logic [31:0] imm_b;
      logic [31:0] imm_j;
      logic        taken;
      logic        stop;
      int          steps;
      exp_pc.delete();
      exp_rd.delete();
      exp_data.delete();
      exp_has_data.delete();
      for (int i = 0; i < 32; i++)
         model_regs[i] = 32'd0;
      pc    = reset_pc;
      stop  = 1'b0;
      steps = 0;
      while (!stop && steps < 200) begin
         w     = imem[pc[7:2]];
         a     = model_regs[w[19:15]];
         b     = model_regs[w[24:20]];
         imm_i = {{20{w[31]}}, w[31:20]};
         imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         val   = 32'd0;
         stop  = (pc == sentinel_pc);
         steps++;
         case (w[6:0])
            7'b0110011: begin
               case (w[14:12])
                  3'b000:  val = (w[31:25] == f7_sub) ? a - b : a + b;
                  3'b111:  val = a & b;
                  3'b110:  val = a | b;
                  3'b100:  val = a ^ b;
                  3'b010:  val = {31'd0, $signed(a) < $signed(b)};
                  3'b001:  val = a << b[4:0];
                  3'b101:  val = a >> b[4:0];
                  default: val = 32'd0;
               endcase
               retire_expected(pc, w[11:7], val, 1'b1);
               pc = pc + 32'd4;
            end
            7'b0010011: begin
               case (w[14:12])
                  3'b000:  val = a + imm_i;
                  3'b111:  val = a & imm_i;
                  3'b110:  val = a | imm_i;
                  default: val = a ^ imm_i;
               endcase
               retire_expected(pc, w[11:7], val, 1'b1);
               pc = pc + 32'd4;
            end
            7'b0110111: begin
               retire_expected(pc, w[11:7], {w[31:12], 12'd0}, 1'b1);
               pc = pc + 32'd4;
            end
            7'b1100011: begin
               case (w[14:12])
                  3'b000:  taken = (a == b);
                  3'b001:  taken = (a != b);
                  default: taken = ($signed(a) < $signed(b));
               endcase
               retire_expected(pc, 5'd0, 32'd0, 1'b0);
               pc = taken ? pc + imm_b : pc + 32'd4;
            end
            7'b1101111: begin
               retire_expected(pc, w[11:7], pc + 32'd4, 1'b1);
               pc = pc + imm_j;
            end
            // opcodes outside the subset never retire
            default: pc = pc + 32'd4;
         endcase
      end
      if (!stop) begin
         $display("reference model never reached the sentinel");
         error_count++;
         test_errors++;
      end
   endtask

   task automatic pulse_reset();
      @(posedge clk);
      reset <= 1'b1;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;
   endtask

   task automatic collect_and_compare(input string name);
      logic done;
      int   n;
      got_pc.delete();
      got_rd.delete();
      got_data.delete();
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (retire_valid) begin
            got_pc.push_back(retire_pc);
            got_rd.push_back(retire_rd);
            got_data.push_back(retire_data);
            if (retire_pc == sentinel_pc)
               done = 1'b1;
         end
      end
      check_value(name, "retire count", exp_pc.size(), got_pc.size());
      n = (exp_pc.size() < got_pc.size()) ? exp_pc.size() : got_pc.size();
      for (int i = 0; i < n; i++) begin
         check_value(name, $sformatf("pc of event %0d", i), exp_pc[i], got_pc[i]);
         check_value(name, $sformatf("rd of event %0d", i), {27'd0, exp_rd[i]},
                     {27'd0, got_rd[i]});
         if (exp_has_data[i])
            check_value(name, $sformatf("data of event %0d", i), exp_data[i], got_data[i]);
      end
      $display("%-10s %0d retired, %0d errors", name, got_pc.size(), test_errors);
   endtask

   task automatic run_program(input string name);
      build_expected();
      pulse_reset();
      collect_and_compare(name);
   endtask

   task automatic test_reset();
      new_program();
      put_word(op_imm(f3_add, 5'd1, 5'd0, 12'd5));
      put_word(op_imm(f3_add, 5'd2, 5'd1, 12'd1));
      end_program();
      build_expected();
      pulse_reset();
      // nothing retires while the pipeline fills
      for (int c = 0; c < 3; c++) begin
         @(negedge clk);
         if (c == 0)
            check_value("reset", "first fetch address", reset_pc, imem_addr);
         check_value("reset", "retire valid during fill", 32'd0, {31'd0, retire_valid});
      end
      collect_and_compare("reset");
   endtask

   task automatic test_forwarding();
      logic [31:0] r;
      r = $urandom;
      new_program();
      put_word(op_imm(f3_add, 5'd1, 5'd0, random_imm12()));
      put_word(op_imm(f3_add, 5'd2, 5'd1, random_imm12()));
      put_word(op_rr(7'h00, f3_add, 5'd3, 5'd1, 5'd2));
      put_word(op_rr(f7_sub, f3_add, 5'd4, 5'd3, 5'd1));
      put_word(op_rr(7'h00, f3_xor, 5'd5, 5'd4, 5'd3));
      put_word(op_rr(7'h00, f3_and, 5'd6, 5'd5, 5'd4));
      put_word(op_rr(7'h00, f3_or, 5'd7, 5'd6, 5'd1));
      put_word(op_rr(7'h00, f3_slt, 5'd8, 5'd4, 5'd3));
      put_word(op_imm(f3_add, 5'd9, 5'd0, 12'd3));
      put_word(op_rr(7'h00, f3_sll, 5'd10, 5'd7, 5'd9));
      put_word(op_rr(7'h00, f3_srl, 5'd11, 5'd7, 5'd9));
      put_word(lui_word(5'd12, r[19:0]));
      put_word(op_imm(f3_or, 5'd13, 5'd12, random_imm12()));
      put_word(op_imm(f3_and, 5'd14, 5'd13, random_imm12()));
      put_word(op_imm(f3_xor, 5'd15, 5'd14, random_imm12()));
      end_program();
      run_program("forwarding");
   endtask

   task automatic test_branches();
      new_program();
      put_word(op_imm(f3_add, 5'd1, 5'd0, 12'd7));
      put_word(op_imm(f3_add, 5'd2, 5'd0, 12'd7));
      put_word(op_imm(f3_add, 5'd3, 5'd0, 12'hffe));
      // each taken branch jumps over exactly the two squashed slots
      put_word(branch_word(f3_beq, 5'd1, 5'd2, 13'd12));
      put_word(op_imm(f3_add, 5'd10, 5'd0, 12'd1));
      put_word(op_imm(f3_add, 5'd11, 5'd0, 12'd2));
      put_word(branch_word(f3_bne, 5'd1, 5'd3, 13'd12));
      put_word(op_imm(f3_add, 5'd10, 5'd0, 12'd3));
      put_word(op_imm(f3_add, 5'd11, 5'd0, 12'd4));
      put_word(branch_word(f3_blt, 5'd3, 5'd1, 13'd12));
      put_word(op_imm(f3_add, 5'd10, 5'd0, 12'd5));
      put_word(op_imm(f3_add, 5'd11, 5'd0, 12'd6));
      // not taken branches fall through
      put_word(branch_word(f3_beq, 5'd1, 5'd3, 13'd8));
      put_word(op_imm(f3_add, 5'd12, 5'd0, 12'd3));
      put_word(branch_word(f3_bne, 5'd1, 5'd2, 13'd8));
      put_word(branch_word(f3_blt, 5'd1, 5'd3, 13'd8));
      put_word(op_rr(7'h00, f3_add, 5'd13, 5'd12, 5'd3));
      end_program();
      run_program("branches");
   endtask

   task automatic test_jal();
      new_program();
      put_word(op_imm(f3_add, 5'd1, 5'd0, 12'd1));
      put_word(jal_word(5'd5, 21'd16));
      put_word(op_imm(f3_add, 5'd2, 5'd0, 12'd9));
      put_word(op_imm(f3_add, 5'd2, 5'd0, 12'd9));
      put_word(op_imm(f3_add, 5'd2, 5'd0, 12'd9));
      put_word(op_imm(f3_add, 5'd6, 5'd5, 12'd0));
      put_word(op_rr(7'h00, f3_add, 5'd7, 5'd5, 5'd1));
      put_word(jal_word(5'd8, 21'd8));
      put_word(op_imm(f3_add, 5'd2, 5'd0, 12'd9));
      put_word(op_rr(f7_sub, f3_add, 5'd9, 5'd8, 5'd5));
      end_program();
      run_program("jal");
   endtask

   task automatic test_x0();
      logic [31:0] r;
      r = $urandom;
      new_program();
      put_word(op_imm(f3_add, 5'd0, 5'd0, random_imm12()));
      put_word(op_rr(7'h00, f3_add, 5'd1, 5'd0, 5'd0));
      put_word(op_imm(f3_add, 5'd0, 5'd1, 12'd5));
      put_word(op_imm(f3_add, 5'd2, 5'd0, 12'd0));
      put_word(lui_word(5'd0, r[19:0]));
      put_word(op_rr(7'h00, f3_or, 5'd3, 5'd0, 5'd0));
      put_word(op_imm(f3_add, 5'd4, 5'd0, 12'd9));
      put_word(op_rr(7'h00, f3_add, 5'd5, 5'd0, 5'd4));
      end_program();
      run_program("x0");
   endtask

   task automatic test_unknown();
      new_program();
      put_word(op_imm(f3_add, 5'd1, 5'd0, random_imm12()));
      put_word({20'h12345, 5'd1, 7'h0b});
      put_word(op_imm(f3_add, 5'd2, 5'd1, 12'd1));
      // load word is outside the supported subset
      put_word({12'h004, 5'd2, 3'b010, 5'd2, 7'h03});
      put_word(op_rr(7'h00, f3_add, 5'd3, 5'd2, 5'd1));
      put_word(32'h0000_0000);
      put_word(op_rr(f7_sub, f3_add, 5'd4, 5'd3, 5'd2));
      end_program();
      run_program("unknown");
   endtask

   initial begin
      clk         = 1'b0;
      reset       = 1'b1;
      cycle_count = 0;
      error_count = 0;
      check_count = 0;
      test_errors = 0;
      load_ptr    = 0;
      sentinel_pc = 32'd0;
      void'($urandom(23));
      new_program();
      test_reset();
      test_forwarding();
      test_branches();
      test_jal();
      test_x0();
      test_unknown();
      $display("summary: %0d tests, %0d checks, %0d errors", num_tests, check_count,
               error_count);
      if (error_count == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* rv_core.f */
logic/rv_pkg.sv
logic/rv_exec_if.sv
logic/rv_decoder.sv
logic/rv_reg_file.sv
logic/rv_alu.sv
logic/rv_branch_unit.sv
logic/rv_core.sv
tests/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/rv_exec_if.sv
  - logic/rv_decoder.sv
  - logic/rv_reg_file.sv
  - logic/rv_alu.sv
  - logic/rv_branch_unit.sv
  - logic/rv_core.sv
  - target: test
    files:
      - tests/rv_core_tb.sv
